// File: rtl/can_config.svh
// Build constants for the CAN receive front end
// Register addresses follow the basic mode map, BTR writes need reset mode
// FIFO depth must be a power of two, at least 2
`ifndef CAN_CONFIG_SVH
`define CAN_CONFIG_SVH

//////////////////////////////////////////
// Host register map
//////////////////////////////////////////
`define CAN_ADDR_MODE   8'd0
`define CAN_ADDR_STATUS 8'd2
`define CAN_ADDR_BTR0   8'd6
`define CAN_ADDR_BTR1   8'd7
// Read-only window onto the receive FIFO head
`define CAN_ADDR_RXBUF  8'd20

//////////////////////////////////////////
// Receive path sizing
//////////////////////////////////////////
`define CAN_FIFO_DEPTH  4
// Recessive samples that mark the bus idle
`define CAN_IDLE_BITS   4'd11
// Equal bits after which a stuff bit follows
`define CAN_STUFF_LIMIT 3'd5

`endif

// File: rtl/can_pkg.sv
// Shared types of the CAN receive front end
// Field widths follow the BTR0/BTR1 layout, each stored as value minus one
`default_nettype none

package can_pkg;

  // Register data and received bytes
  typedef logic [7:0] byte_t;
  // Host address
  typedef logic [7:0] reg_addr_t;

  // Bus timing fields
  typedef logic [5:0] brp_t;
  typedef logic [1:0] sjw_t;
  typedef logic [3:0] tseg1_t;
  typedef logic [2:0] tseg2_t;

  // Segment walk inside one bit
  typedef enum logic [1:0] {BTL_SYNC, BTL_TSEG1, BTL_TSEG2} btl_state_t;

  // Bit stream framing
  typedef enum logic {RX_IDLE, RX_FRAME} rx_state_t;

endpackage

`default_nettype wire

// File: rtl/can_registers.sv
// Host registers: mode, status, BTR0, BTR1 and the RX FIFO window
// Reads are registered, data one cycle after re_i; reading RXBUF pops the FIFO
// BTR0/BTR1 only accept writes while reset mode is set
`timescale 1ns/1ps
`default_nettype none
`include "can_config.svh"

module can_registers
(
  input  wire                clk_i,
  input  wire                rst,
  input  wire                re_i,
  input  wire                we_i,
  input  wire can_pkg::reg_addr_t addr_i,
  input  wire can_pkg::byte_t     data_i,
  output can_pkg::byte_t     reg_data_o,
  output logic               irq_n_o,
  input  wire can_pkg::byte_t     fifo_data_i,
  input  wire                fifo_not_empty_i,
  input  wire                stuff_err_i,
  input  wire                overrun_i,
  output logic               fifo_pop_o,
  output logic               reset_mode_o,
  output can_pkg::brp_t      brp_o,
  output can_pkg::sjw_t      sjw_o,
  output can_pkg::tseg1_t    tseg1_o,
  output can_pkg::tseg2_t    tseg2_o
);

  logic           stuff_err_flag;
  logic           overrun_flag;
  logic           set_reset_mode;
  can_pkg::byte_t rd_mux;

  // Writing 1 to mode bit 0 also clears the sticky status flags
  assign set_reset_mode = we_i & (addr_i == `CAN_ADDR_MODE) & data_i[0];

  //////////////////////////////////////////
  // Mode and bus timing registers
  //////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      reset_mode_o <= 1'b1;
      brp_o        <= '0;
      sjw_o        <= '0;
      tseg1_o      <= '0;
      tseg2_o      <= '0;
    end
    else if (we_i)
    begin
      if (addr_i == `CAN_ADDR_MODE)
        reset_mode_o <= data_i[0];
      // Timing only changes while the core is held
      if (reset_mode_o && (addr_i == `CAN_ADDR_BTR0))
      begin
        sjw_o <= data_i[7:6];
        brp_o <= data_i[5:0];
      end
      if (reset_mode_o && (addr_i == `CAN_ADDR_BTR1))
      begin
        tseg2_o <= data_i[6:4];
        tseg1_o <= data_i[3:0];
      end
    end
  end

  // Sticky error flags, clear wins over a same-cycle set
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      stuff_err_flag <= 1'b0;
      overrun_flag   <= 1'b0;
    end
    else if (set_reset_mode)
    begin
      stuff_err_flag <= 1'b0;
      overrun_flag   <= 1'b0;
    end
    else
    begin
      if (stuff_err_i)
        stuff_err_flag <= 1'b1;
      if (overrun_i)
        overrun_flag <= 1'b1;
    end
  end

  //////////////////////////////////////////
  // Read path
  //////////////////////////////////////////
  always_comb
  begin
    case (addr_i)
      `CAN_ADDR_MODE:   rd_mux = {7'd0, reset_mode_o};
      `CAN_ADDR_STATUS: rd_mux = {5'd0, overrun_flag, stuff_err_flag, fifo_not_empty_i};
      `CAN_ADDR_BTR0:   rd_mux = {sjw_o, brp_o};
      `CAN_ADDR_BTR1:   rd_mux = {1'b0, tseg2_o, tseg1_o};
      // Empty FIFO reads back as zero
      `CAN_ADDR_RXBUF:  rd_mux = fifo_not_empty_i ? fifo_data_i : 8'd0;
      default:          rd_mux = 8'd0;
    endcase
  end

  // Read data held until the next read strobe
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      reg_data_o <= 8'd0;
    else if (re_i)
      reg_data_o <= rd_mux;
  end

  // Pop only a head that is really there
  assign fifo_pop_o = re_i & (addr_i == `CAN_ADDR_RXBUF) & fifo_not_empty_i;
  // Active low, pending while the FIFO holds data
  assign irq_n_o = ~fifo_not_empty_i;

  // Host never reads and writes in the same cycle
  host_rw_excl_a: assert property (@(posedge clk_i) disable iff (rst)
    !(we_i && re_i));

endmodule

`default_nettype wire

// File: rtl/can_btl.sv
// Bit timing: quantum = (brp+1)*2 clocks, bit = 1 + (tseg1+1) + (tseg2+1) quanta
// Sample point at the end of TSEG1; rx_i passes a two-flop synchronizer first
// Hard sync on a falling edge while idle, resync limited to sjw+1 quanta
`timescale 1ns/1ps
`default_nettype none

module can_btl
(
  input  wire                clk_i,
  input  wire                rst,
  input  wire                rx_i,
  input  wire                reset_mode_i,
  input  wire can_pkg::brp_t   brp_i,
  input  wire can_pkg::sjw_t   sjw_i,
  input  wire can_pkg::tseg1_t tseg1_i,
  input  wire can_pkg::tseg2_t tseg2_i,
  input  wire                rx_idle_i,
  output logic               sample_point_o,
  output logic               sampled_bit_o
);

  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic [6:0]          tq_cnt;
  logic [3:0]          seg_cnt;
  logic [3:0]          sjw_len;
  can_pkg::btl_state_t state;
  logic                tq_end;
  logic                fall_edge;
  logic                late_fix;
  logic                early_fix;
  logic                restart;

  // Synchronizer plus one stage for edge detection, all recessive at reset
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Last clock of a quantum is count 2*brp+1
  assign tq_end    = (tq_cnt == {brp_i, 1'b1});
  assign sjw_len   = {2'b00, sjw_i} + 4'd1;
  assign fall_edge = rx_prev & ~rx_sync;

  // Phase error fits in the jump width, edge simply becomes the new SYNC
  assign late_fix  = (state == can_pkg::BTL_TSEG1) && (seg_cnt < sjw_len);
  assign early_fix = (state == can_pkg::BTL_TSEG2) &&
                     (({2'b00, tseg2_i} + 5'd1) <= ({1'b0, seg_cnt} + {1'b0, sjw_len}));
  // Edge in SYNC outside idle needs no correction
  assign restart   = fall_edge & (rx_idle_i | late_fix | early_fix);

  //////////////////////////////////////////
  // Quantum prescaler
  //////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      tq_cnt <= 7'd0;
    else if (reset_mode_i || restart || tq_end)
      tq_cnt <= 7'd0;
    else
      tq_cnt <= tq_cnt + 7'd1;
  end

  //////////////////////////////////////////
  // Segment FSM and sample point
  //////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      state          <= can_pkg::BTL_SYNC;
      seg_cnt        <= 4'd0;
      sample_point_o <= 1'b0;
      sampled_bit_o  <= 1'b1;
    end
    else
    begin
      sample_point_o <= 1'b0;
      if (reset_mode_i || restart)
      begin
        state   <= can_pkg::BTL_SYNC;
        seg_cnt <= 4'd0;
      end
      // Late edge, lengthen TSEG1 by the full jump width
      else if (fall_edge && (state == can_pkg::BTL_TSEG1))
        seg_cnt <= seg_cnt - sjw_len;
      // Early edge, skip jump width quanta of TSEG2
      else if (fall_edge && (state == can_pkg::BTL_TSEG2))
        seg_cnt <= seg_cnt + sjw_len;
      else if (tq_end)
      begin
        case (state)
          can_pkg::BTL_SYNC:
          begin
            state   <= can_pkg::BTL_TSEG1;
            seg_cnt <= 4'd0;
          end
          can_pkg::BTL_TSEG1:
            if (seg_cnt == tseg1_i)
            begin
              state          <= can_pkg::BTL_TSEG2;
              seg_cnt        <= 4'd0;
              sample_point_o <= 1'b1;
              sampled_bit_o  <= rx_sync;
            end
            else
              seg_cnt <= seg_cnt + 4'd1;
          default:
            if (seg_cnt == {1'b0, tseg2_i})
            begin
              state   <= can_pkg::BTL_SYNC;
              seg_cnt <= 4'd0;
            end
            else
              seg_cnt <= seg_cnt + 4'd1;
        endcase
      end
    end
  end

  // One sample per bit, never back to back
  sample_single_a: assert property (@(posedge clk_i) disable iff (rst)
    sample_point_o |=> !sample_point_o);

endmodule

`default_nettype wire

// File: rtl/can_destuff.sv
// Frame start after 11 recessive samples; SOF is stored nowhere but starts the stuff run
// Six dominant bits in a row are a stuff error, six recessive bits end the frame
// Bytes MSB first, one byte buffered towards the FIFO, later bytes dropped as overrun
`timescale 1ns/1ps
`default_nettype none
`include "can_config.svh"

module can_destuff
(
  input  wire                clk_i,
  input  wire                rst,
  input  wire                reset_mode_i,
  input  wire                sample_point_i,
  input  wire                sampled_bit_i,
  input  wire                byte_ready_i,
  output logic               byte_valid_o,
  output can_pkg::byte_t     byte_data_o,
  output logic               rx_idle_o,
  output logic               stuff_err_o,
  output logic               overrun_o
);

  can_pkg::rx_state_t state;
  logic [3:0]         idle_cnt;
  logic [2:0]         run_cnt;
  logic               last_bit;
  logic [2:0]         bit_cnt;
  can_pkg::byte_t     shift_q;
  logic               stuff_slot;
  logic               keep_bit;
  logic               byte_done;
  logic               load_byte;

  assign rx_idle_o  = (state == can_pkg::RX_IDLE);
  // Bit right after a full run is the stuff bit
  assign stuff_slot = (run_cnt == `CAN_STUFF_LIMIT);
  assign keep_bit   = sample_point_i & ~reset_mode_i & ~rx_idle_o & ~stuff_slot;
  assign byte_done  = keep_bit & (bit_cnt == 3'd7);
  // Slot free or being emptied this edge
  assign load_byte  = byte_done & (~byte_valid_o | byte_ready_i);

  //////////////////////////////////////////
  // Framing and destuffing
  //////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      state       <= can_pkg::RX_IDLE;
      idle_cnt    <= 4'd0;
      run_cnt     <= 3'd0;
      last_bit    <= 1'b1;
      bit_cnt     <= 3'd0;
      stuff_err_o <= 1'b0;
    end
    else
    begin
      stuff_err_o <= 1'b0;
      if (reset_mode_i)
      begin
        state    <= can_pkg::RX_IDLE;
        idle_cnt <= 4'd0;
        run_cnt  <= 3'd0;
      end
      else if (sample_point_i && rx_idle_o)
      begin
        // Saturating count of recessive samples
        if (sampled_bit_i)
        begin
          if (idle_cnt != `CAN_IDLE_BITS)
            idle_cnt <= idle_cnt + 4'd1;
        end
        else if (idle_cnt == `CAN_IDLE_BITS)
        begin
          state    <= can_pkg::RX_FRAME;
          idle_cnt <= 4'd0;
          run_cnt  <= 3'd1;
          last_bit <= 1'b0;
          bit_cnt  <= 3'd0;
        end
        else
          idle_cnt <= 4'd0;
      end
      else if (sample_point_i && stuff_slot)
      begin
        if (sampled_bit_i != last_bit)
        begin
          // Proper stuff bit opens a new run
          run_cnt  <= 3'd1;
          last_bit <= sampled_bit_i;
        end
        else if (sampled_bit_i)
        begin
          // Bus back to recessive, the run already counts towards idle
          state    <= can_pkg::RX_IDLE;
          idle_cnt <= {1'b0, `CAN_STUFF_LIMIT} + 4'd1;
        end
        else
        begin
          state       <= can_pkg::RX_IDLE;
          idle_cnt    <= 4'd0;
          stuff_err_o <= 1'b1;
        end
      end
      else if (keep_bit)
      begin
        run_cnt  <= (sampled_bit_i == last_bit) ? run_cnt + 3'd1 : 3'd1;
        last_bit <= sampled_bit_i;
        bit_cnt  <= bit_cnt + 3'd1;
      end
    end
  end

  // Shift register of the kept bits
  always_ff @(posedge clk_i)
  begin
    if (keep_bit)
      shift_q <= {shift_q[6:0], sampled_bit_i};
  end

  //////////////////////////////////////////
  // Byte handshake towards the FIFO
  //////////////////////////////////////////
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      byte_valid_o <= 1'b0;
      overrun_o    <= 1'b0;
    end
    else
    begin
      overrun_o <= 1'b0;
      if (reset_mode_i)
        byte_valid_o <= 1'b0;
      else if (load_byte)
        byte_valid_o <= 1'b1;
      else if (byte_done)
        overrun_o <= 1'b1;
      else if (byte_ready_i)
        byte_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load_byte)
      byte_data_o <= {shift_q[6:0], sampled_bit_i};
  end

  // Offered byte holds until the FIFO takes it
  byte_hold_a: assert property (@(posedge clk_i) disable iff (rst)
    byte_valid_o && !byte_ready_i |=> $stable(byte_data_o));

endmodule

`default_nettype wire

// File: rtl/can_rx_fifo.sv
// Receive byte FIFO, DEPTH a power of two and at least 2
// Push on valid/ready, pop by host read; head_o is the oldest byte
`timescale 1ns/1ps
`default_nettype none
`include "can_config.svh"

module can_rx_fifo
#(
  parameter int DEPTH = `CAN_FIFO_DEPTH
)
(
  input  wire                clk_i,
  input  wire                rst,
  input  wire                push_valid_i,
  input  wire can_pkg::byte_t push_data_i,
  input  wire                pop_i,
  output logic               push_ready_o,
  output can_pkg::byte_t     head_o,
  output logic               not_empty_o
);

  localparam int AW = $clog2(DEPTH);

  can_pkg::byte_t mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;
  logic           push;
  logic           pop;

  assign push_ready_o = (count != (AW+1)'(DEPTH));
  assign not_empty_o  = (count != '0);
  assign push         = push_valid_i & push_ready_o;
  // A pop on an empty FIFO is ignored
  assign pop          = pop_i & not_empty_o;
  assign head_o       = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr] <= push_data_i;
  end

  // Pointers wrap by width, occupancy tracks both sides
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + AW'(1);
      if (pop)
        rd_ptr <= rd_ptr + AW'(1);
      case ({push, pop})
        2'b10:   count <= count + (AW+1)'(1);
        2'b01:   count <= count - (AW+1)'(1);
        default: count <= count;
      endcase
    end
  end

  // Host side only pops a FIFO that holds data
  pop_nonempty_a: assert property (@(posedge clk_i) disable iff (rst)
    pop_i |-> not_empty_o);

endmodule

`default_nettype wire

// File: rtl/can_top.sv
// Receive-only CAN bit front end
// Host port: registered reads one cycle after re_i, irq_n_o low while RX data waits
`timescale 1ns/1ps
`default_nettype none

module can_top
(
  input  wire                clk_i,
  input  wire                rst,
  input  wire                rx_i,
  input  wire                re_i,
  input  wire                we_i,
  input  wire can_pkg::reg_addr_t addr_i,
  input  wire can_pkg::byte_t     data_i,
  output can_pkg::byte_t     reg_data_o,
  output logic               irq_n_o
);

  // Register block outputs
  logic            reset_mode;
  can_pkg::brp_t   brp;
  can_pkg::sjw_t   sjw;
  can_pkg::tseg1_t tseg1;
  can_pkg::tseg2_t tseg2;
  logic            fifo_pop;

  // Bit timing to bit stream
  logic            sample_point;
  logic            sampled_bit;
  logic            rx_idle;

  // Bit stream to FIFO and status
  logic            byte_valid;
  logic            byte_ready;
  can_pkg::byte_t  byte_data;
  logic            stuff_err;
  logic            overrun;
  can_pkg::byte_t  fifo_head;
  logic            fifo_not_empty;

  can_registers i_can_registers (
    .clk_i(clk_i), .rst(rst), .re_i(re_i), .we_i(we_i),
    .addr_i(addr_i), .data_i(data_i), .reg_data_o(reg_data_o), .irq_n_o(irq_n_o),
    .fifo_data_i(fifo_head), .fifo_not_empty_i(fifo_not_empty),
    .stuff_err_i(stuff_err), .overrun_i(overrun), .fifo_pop_o(fifo_pop),
    .reset_mode_o(reset_mode), .brp_o(brp), .sjw_o(sjw),
    .tseg1_o(tseg1), .tseg2_o(tseg2)
  );

  can_btl i_can_btl (
    .clk_i(clk_i), .rst(rst), .rx_i(rx_i), .reset_mode_i(reset_mode),
    .brp_i(brp), .sjw_i(sjw), .tseg1_i(tseg1), .tseg2_i(tseg2),
    .rx_idle_i(rx_idle), .sample_point_o(sample_point), .sampled_bit_o(sampled_bit)
  );

  can_destuff i_can_destuff (
    .clk_i(clk_i), .rst(rst), .reset_mode_i(reset_mode),
    .sample_point_i(sample_point), .sampled_bit_i(sampled_bit),
    .byte_ready_i(byte_ready), .byte_valid_o(byte_valid), .byte_data_o(byte_data),
    .rx_idle_o(rx_idle), .stuff_err_o(stuff_err), .overrun_o(overrun)
  );

  can_rx_fifo i_can_rx_fifo (
    .clk_i(clk_i), .rst(rst), .push_valid_i(byte_valid), .push_data_i(byte_data),
    .pop_i(fifo_pop), .push_ready_o(byte_ready), .head_o(fifo_head),
    .not_empty_o(fifo_not_empty)
  );

endmodule

`default_nettype wire

// File: testbench/tb_can_top.sv
// Testbench for can_top, vectors come from testbench/can_input.txt
// Builds its own stuffed bit stream, bit period taken from the BTR fields
// Clock 40 ns, inputs driven 5 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none
`include "can_config.svh"

module tb_can_top;

  localparam int NUM_FIELDS = 14;
  localparam int MAX_TESTS  = 16;
  localparam int WAIT_LIMIT = 20000;

  logic               clk_i;
  logic               rst;
  logic               rx_i;
  logic               re_i;
  logic               we_i;
  can_pkg::reg_addr_t addr_i;
  can_pkg::byte_t     data_i;
  can_pkg::byte_t     reg_data_o;
  logic               irq_n_o;

  // Vector table, 14 fields per test
  can_pkg::byte_t vec_mem [0:255];
  can_pkg::byte_t tx_bytes [$];
  int             bit_clks;
  int             test_errors;
  int             pass_count;
  int             fail_count;
  logic           timed_out;
  integer         seed;

  can_top UUT (
    .clk_i(clk_i), .rst(rst), .rx_i(rx_i), .re_i(re_i), .we_i(we_i),
    .addr_i(addr_i), .data_i(data_i), .reg_data_o(reg_data_o), .irq_n_o(irq_n_o)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////
  function automatic can_pkg::byte_t vector_field(input int t, input int f);
    logic [7:0] idx;
    idx = 8'(t * NUM_FIELDS + f);
    return vec_mem[idx];
  endfunction

  // Counts rising edges, returns at the drive point after the last one
  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++)
      @(posedge clk_i);
    #5;
  endtask

  task automatic write_reg(input can_pkg::reg_addr_t addr, input can_pkg::byte_t data);
    addr_i = addr;
    data_i = data;
    we_i   = 1'b1;
    wait_clocks(1);
    we_i   = 1'b0;
  endtask

  // Read data is registered, valid after the edge that saw re_i
  task automatic read_reg(input can_pkg::reg_addr_t addr, output can_pkg::byte_t data);
    addr_i = addr;
    re_i   = 1'b1;
    wait_clocks(1);
    re_i   = 1'b0;
    data   = reg_data_o;
  endtask

  task automatic report_mismatch(input string name, input can_pkg::byte_t got,
                                 input can_pkg::byte_t exp);
    $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    test_errors++;
  endtask

  task automatic finish_test(input int id);
    if (test_errors == 0)
    begin
      pass_count++;
      $display("Test %0d finished: ok", id);
    end
    else
    begin
      fail_count++;
      $display("Test %0d finished: %0d errors", id, test_errors);
    end
  endtask

  //////////////////////////////////////////
  // Serial bit driver
  //////////////////////////////////////////
  task automatic send_bit(input logic b);
    rx_i = b;
    wait_clocks(bit_clks);
  endtask

  // Idle, SOF, bytes MSB first with a complement bit after five equal bits, idle
  task automatic send_frame(input int count, input logic violate);
    can_pkg::byte_t sh;
    logic           last;
    logic           b;
    int             run;
    for (int i = 0; i < int'(`CAN_IDLE_BITS) + 2; i++)
      send_bit(1'b1);
    // SOF opens the first run
    send_bit(1'b0);
    last = 1'b0;
    run  = 1;
    for (int i = 0; i < count; i++)
    begin
      sh = tx_bytes[i];
      for (int k = 0; k < 8; k++)
      begin
        b  = sh[7];
        sh = sh << 1;
        send_bit(b);
        run  = (b == last) ? run + 1 : 1;
        last = b;
        if (run == int'(`CAN_STUFF_LIMIT))
        begin
          send_bit(~last);
          last = ~last;
          run  = 1;
        end
      end
    end
    // Dominant run with no stuff bit at all
    if (violate)
      for (int i = 0; i < 6; i++)
        send_bit(1'b0);
    for (int i = 0; i < int'(`CAN_IDLE_BITS) + 2; i++)
      send_bit(1'b1);
  endtask

  //////////////////////////////////////////
  // One vector from the table
  //////////////////////////////////////////
  task automatic run_vector(input int t);
    can_pkg::byte_t id;
    can_pkg::byte_t brp;
    can_pkg::byte_t tseg1;
    can_pkg::byte_t tseg2;
    can_pkg::byte_t sjw;
    can_pkg::byte_t flags;
    can_pkg::byte_t exp_status;
    can_pkg::byte_t exp_held;
    can_pkg::byte_t btr0;
    can_pkg::byte_t btr1;
    can_pkg::byte_t rd;
    int             count;
    int             readable;
    int             n;
    integer         rnd;
    id         = vector_field(t, 0);
    brp        = vector_field(t, 1);
    tseg1      = vector_field(t, 2);
    tseg2      = vector_field(t, 3);
    sjw        = vector_field(t, 4);
    count      = int'(vector_field(t, 5));
    flags      = vector_field(t, 12);
    exp_status = vector_field(t, 13);
    test_errors = 0;
    // Quantum is (brp+1)*2 clocks, bit is SYNC + TSEG1 + TSEG2
    bit_clks = (int'(brp[5:0]) + 1) * 2 * (int'(tseg1[3:0]) + int'(tseg2[2:0]) + 3);
    tx_bytes.delete();
    for (int i = 0; i < count; i++)
    begin
      if (flags[2])
      begin
        rnd = $random(seed);
        tx_bytes.push_back(rnd[7:0]);
      end
      else
        tx_bytes.push_back(vector_field(t, 6 + i));
    end
    // Timing only writable in reset mode
    btr0 = {sjw[1:0], brp[5:0]};
    btr1 = {1'b0, tseg2[2:0], tseg1[3:0]};
    write_reg(`CAN_ADDR_MODE, 8'h01);
    write_reg(`CAN_ADDR_BTR0, btr0);
    write_reg(`CAN_ADDR_BTR1, btr1);
    read_reg(`CAN_ADDR_BTR0, rd);
    if (rd !== btr0)
      report_mismatch("reg_data_o BTR0", rd, btr0);
    read_reg(`CAN_ADDR_BTR1, rd);
    if (rd !== btr1)
      report_mismatch("reg_data_o BTR1", rd, btr1);
    if (!flags[1])
      write_reg(`CAN_ADDR_MODE, 8'h00);
    send_frame(count, flags[0]);
    // Held core stores nothing, full FIFO keeps the oldest bytes
    readable = flags[1] ? 0 : ((count > `CAN_FIFO_DEPTH) ? `CAN_FIFO_DEPTH : count);
    if (readable > 0)
    begin
      n = 0;
      while (irq_n_o && (n < WAIT_LIMIT))
      begin
        wait_clocks(1);
        n++;
      end
      if (irq_n_o)
      begin
        $display("Test %0d: no interrupt after the frame, gave up waiting", int'(id));
        test_errors++;
        timed_out = 1'b1;
      end
    end
    if (!timed_out)
    begin
      read_reg(`CAN_ADDR_STATUS, rd);
      if (rd !== exp_status)
        report_mismatch("reg_data_o STATUS", rd, exp_status);
      // Reset mode clears sticky flags and drops a byte still waiting for the FIFO
      write_reg(`CAN_ADDR_MODE, 8'h01);
      exp_held = (readable > 0) ? 8'h01 : 8'h00;
      read_reg(`CAN_ADDR_STATUS, rd);
      if (rd !== exp_held)
        report_mismatch("reg_data_o STATUS after mode write", rd, exp_held);
      for (int i = 0; i < readable; i++)
      begin
        read_reg(`CAN_ADDR_RXBUF, rd);
        if (rd !== tx_bytes[i])
          report_mismatch("reg_data_o RXBUF", rd, tx_bytes[i]);
      end
      read_reg(`CAN_ADDR_STATUS, rd);
      if (rd !== 8'h00)
        report_mismatch("reg_data_o STATUS after pops", rd, 8'h00);
      if (irq_n_o !== 1'b1)
        report_mismatch("irq_n_o", {7'd0, irq_n_o}, 8'h01);
    end
    finish_test(int'(id));
  endtask

  //////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////
  initial
  begin
    can_pkg::byte_t rd;
    int             t;
    clk_i       = 1'b0;
    rst         = 1'b1;
    rx_i        = 1'b1;
    re_i        = 1'b0;
    we_i        = 1'b0;
    addr_i      = 8'h00;
    data_i      = 8'h00;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    bit_clks    = 1;
    seed        = 32'h78cb_2725;
    // Unused rows read as id 0, which ends the table
    for (int i = 0; i < 256; i++)
      vec_mem[8'(i)] = 8'h00;
    $readmemh("testbench/can_input.txt", vec_mem);
    wait_clocks(16);
    rst = 1'b0;
    wait_clocks(2);

    // Reset values of mode, status and interrupt
    read_reg(`CAN_ADDR_MODE, rd);
    if (rd !== 8'h01)
      report_mismatch("reg_data_o MODE", rd, 8'h01);
    read_reg(`CAN_ADDR_STATUS, rd);
    if (rd !== 8'h00)
      report_mismatch("reg_data_o STATUS", rd, 8'h00);
    if (irq_n_o !== 1'b1)
      report_mismatch("irq_n_o", {7'd0, irq_n_o}, 8'h01);
    finish_test(0);

    t = 0;
    while ((t < MAX_TESTS) && (vector_field(t, 0) != 8'h00) && !timed_out)
    begin
      run_vector(t);
      t++;
    end

    $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if ((fail_count == 0) && !timed_out)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/can_pkg.sv
rtl/can_registers.sv
rtl/can_btl.sv
rtl/can_destuff.sv
rtl/can_rx_fifo.sv
rtl/can_top.sv
testbench/tb_can_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CAN receive testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f filelist.f --top-module tb_can_top \
  --Mdir obj_dir -o tb_can_top

./obj_dir/tb_can_top 2>&1 | tee sim.log

if grep -qx "Testbench passed" sim.log
then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

// File: testbench/can_input.txt
// Columns: id brp tseg1 tseg2 sjw count b0 b1 b2 b3 b4 b5 flags status
// flags bit0 = six dominant bits without stuff, bit1 = stay in reset mode, bit2 = random bytes
// status is the expected status register right after the frame
01 01 05 02 00 04 00 FF 55 A3 00 00 00 01
02 01 05 02 01 02 0F 80 00 00 00 00 00 01
03 01 05 02 00 02 C3 3C 00 00 00 00 01 03
04 01 05 02 00 06 11 22 33 44 55 66 00 05
05 01 05 02 00 03 AA 55 F0 00 00 00 02 00
06 00 03 01 01 04 00 00 00 00 00 00 04 01
07 02 07 03 01 03 FF 00 7E 00 00 00 00 01
08 01 04 03 02 04 00 00 00 00 00 00 04 01
